/* include/sdram_settings.svh */
// sdram timing constants

`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// ------------------------------
// chip timing, in clocks
// ------------------------------

// read latency; the six-phase slot cycle only works with 2
`define SDRAM_CAS_LATENCY 2

// active to read/write, tRCD 20ns at up to 100MHz
`define SDRAM_RCD 2

// 64ms / 8192 rows = 7.8us, 842 clocks at 108MHz
`define SDRAM_REFRESH_CYCLES 842

// ------------------------------
// startup
// ------------------------------

// six-clock cycles after init_n before traffic
`define SDRAM_INIT_CYCLES 31

// mode register
//   [12:10] reserved 000
//   [9]     single word write
//   [8:7]   standard operation
//   [6:4]   cas latency 2
//   [3]     sequential
//   [2:0]   burst of 1
`define SDRAM_MODE 13'h220

`endif

/* hw/sdram_pkg.sv */
// sdram controller types

`default_nettype none

package sdram_pkg;

	// ------------------------------
	// bus widths
	// ------------------------------
	typedef logic [15:0] word_t;   // one dq word
	typedef logic [23:1] waddr_t;  // user word address
	typedef logic [12:0] row_t;    // row, also the whole a bus
	typedef logic [8:0]  col_t;    // column
	typedef logic [1:0]  bank_t;
	typedef logic [1:0]  mask_t;   // upper, lower byte

	// ------------------------------
	// chip commands
	// ------------------------------
	// bits are ncs, nras, ncas, nwe
	typedef enum logic [3:0] {
		inhibit      = 4'b1111,
		nop          = 4'b0111,
		active       = 4'b0011,
		read         = 4'b0101,
		write        = 4'b0100,
		burst_term   = 4'b0110,
		precharge    = 4'b0010,
		auto_refresh = 4'b0001,
		load_mode    = 4'b0000
	} cmd_t;

	// six-clock slot cycle, port a first then port b
	typedef enum logic [2:0] {
		ras_a = 3'd0,
		gap_a = 3'd1,
		cas_a = 3'd2,
		ras_b = 3'd3,
		gap_b = 3'd4,
		cas_b = 3'd5
	} phase_t;

endpackage

`default_nettype wire

/* hw/sdram_init.sv */
// sdram startup sequencer

`timescale 1ns/10ps
`default_nettype none

`include "sdram_settings.svh"

module sdram_init (
	input  logic              clk,
	input  logic              init_n,
	input  sdram_pkg::phase_t phase,     // from the scheduler
	output sdram_pkg::cmd_t   init_cmd,  // registered by the scheduler
	output sdram_pkg::row_t   init_a,
	output logic              ready      // user traffic allowed
);

	import sdram_pkg::*;

	localparam int cnt_w = $clog2(`SDRAM_INIT_CYCLES + 1);

	logic [cnt_w-1:0] count;  // cycles left before traffic

	// ------------------------------
	// cycle countdown
	// ------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			count <= cnt_w'(`SDRAM_INIT_CYCLES);
			ready <= 1'b0;
		end else begin
			// step once per six-clock cycle
			if (phase == cas_b && count != '0)
				count <= count - 1'b1;
			ready <= (count == '0);  // one clock behind the count
		end
	end

	// ------------------------------
	// command per count
	// ------------------------------
	// only on the first clock of a cycle
	always_comb begin
		init_cmd = nop;
		init_a   = '0;
		if (phase == ras_a) begin
			case (count)
				15: begin
					init_cmd   = precharge;
					init_a[10] = 1'b1;  // all banks
				end
				10, 8: init_cmd = auto_refresh;  // two refreshes
				2: begin
					init_cmd = load_mode;  // bank 0 set by scheduler
					init_a   = `SDRAM_MODE;
				end
				default: init_cmd = nop;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/sdram_port.sv */
// sdram user port

`timescale 1ns/10ps
`default_nettype none

module sdram_port #(
	parameter bit bank_hi = 1'b0  // which half of the banks
) (
	input  logic              clk,
	input  logic              init_n,
	// user side, toggle handshake
	input  logic              req,
	input  logic              we,
	input  sdram_pkg::waddr_t a,
	input  sdram_pkg::mask_t  ds,
	input  sdram_pkg::word_t  d,
	output logic              ack,
	output sdram_pkg::word_t  q,
	// scheduler side
	input  logic              accept,      // our active slot
	input  logic              write_done,
	input  logic              read_done,   // dq_in valid now
	input  sdram_pkg::word_t  dq_in,
	output logic              pending,
	output sdram_pkg::bank_t  bank,
	output sdram_pkg::row_t   row,
	output sdram_pkg::col_t   col,
	output logic              we_l,
	output logic              oe_l,
	output sdram_pkg::mask_t  ds_l,
	output sdram_pkg::word_t  din_l
);

	import sdram_pkg::*;

	bank_t bank_l;  // latched request address
	row_t  row_l;

	// new request whenever req and ack differ
	assign pending = req ^ ack;

	// ------------------------------
	// address to scheduler
	// ------------------------------
	// the active command is registered on the accept edge itself,
	// so the slot clock sees the live address, later clocks the latch
	assign bank = accept ? {bank_hi, a[23]} : bank_l;
	assign row  = accept ? a[22:10] : row_l;

	// ------------------------------
	// slot flags and ack
	// ------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			ack  <= 1'b0;
			we_l <= 1'b0;
			oe_l <= 1'b0;
		end else begin
			if (accept) begin
				// empty slot clears both flags
				we_l <= pending & we;
				oe_l <= pending & ~we;
			end
			if (write_done || read_done)
				ack <= req;  // access finished
		end
	end

	// ------------------------------
	// request latch and read data
	// ------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			bank_l <= {bank_hi, a[23]};  // port picks the bank half
			row_l  <= a[22:10];
			col    <= a[9:1];
			ds_l   <= ds;
			din_l  <= d;
		end
		if (read_done)
			q <= dq_in;
	end

endmodule

`default_nettype wire

/* hw/sdram_sched.sv */
// sdram slot scheduler

`timescale 1ns/10ps
`default_nettype none

`include "sdram_settings.svh"

module sdram_sched (
	input  logic              clk,
	input  logic              init_n,
	// startup
	input  logic              ready,
	input  sdram_pkg::cmd_t   init_cmd,
	input  sdram_pkg::row_t   init_a,
	output sdram_pkg::phase_t phase,
	// port a
	input  logic              pending_a,
	input  sdram_pkg::bank_t  bank_a,
	input  sdram_pkg::row_t   row_a,
	input  sdram_pkg::col_t   col_a,
	input  logic              we_l_a,
	input  logic              oe_l_a,
	input  sdram_pkg::mask_t  ds_l_a,
	input  sdram_pkg::word_t  din_l_a,
	output logic              accept_a,
	output logic              write_done_a,
	output logic              read_done_a,
	// port b
	input  logic              pending_b,
	input  sdram_pkg::bank_t  bank_b,
	input  sdram_pkg::row_t   row_b,
	input  sdram_pkg::col_t   col_b,
	input  logic              we_l_b,
	input  logic              oe_l_b,
	input  sdram_pkg::mask_t  ds_l_b,
	input  sdram_pkg::word_t  din_l_b,
	output logic              accept_b,
	output logic              write_done_b,
	output logic              read_done_b,
	// chip pins
	input  sdram_pkg::word_t  dq_in,
	output sdram_pkg::word_t  dq_rd,   // read data towards the ports
	output sdram_pkg::cmd_t   cmd,
	output sdram_pkg::row_t   sd_a,
	output sdram_pkg::bank_t  sd_ba,
	output sdram_pkg::mask_t  dqm,
	output sdram_pkg::word_t  dq_out,
	output logic              dq_oe
);

	import sdram_pkg::*;

	localparam int cyc_len = 6;
	localparam int rd_lag  = `SDRAM_CAS_LATENCY + 1;  // pin register + cl
	localparam int rfsh_w  = $clog2(`SDRAM_REFRESH_CYCLES + 1);

	// where each slot sits in the cycle
	localparam phase_t cas_a_ph = phase_t'(int'(ras_a) + `SDRAM_RCD);
	localparam phase_t cas_b_ph = phase_t'(int'(ras_b) + `SDRAM_RCD);
	localparam phase_t rd_a_ph  = phase_t'((int'(cas_a_ph) + rd_lag) % cyc_len);
	localparam phase_t rd_b_ph  = phase_t'((int'(cas_b_ph) + rd_lag) % cyc_len);

	logic [rfsh_w-1:0] rfsh_cnt;  // clocks since last refresh
	logic              need_rfsh;
	logic              rfsh_go;
	logic              busy_a;    // port a holds its slot this cycle
	logic              busy_b;

	// next pin values
	cmd_t  cmd_n;
	row_t  a_n;
	bank_t ba_n;
	mask_t dqm_n;
	word_t dout_n;
	logic  oe_n;

	assign need_rfsh = (rfsh_cnt >= rfsh_w'(`SDRAM_REFRESH_CYCLES));
	assign busy_a    = we_l_a | oe_l_a;
	assign busy_b    = we_l_b | oe_l_b;

	// ------------------------------
	// port strobes
	// ------------------------------
	assign accept_a     = ready && (phase == ras_a);
	assign accept_b     = ready && (phase == ras_b);
	assign write_done_a = we_l_a && (phase == cas_a_ph);  // ack with the write
	assign write_done_b = we_l_b && (phase == cas_b_ph);
	assign read_done_a  = oe_l_a && (phase == rd_a_ph);   // data on dq now
	assign read_done_b  = oe_l_b && (phase == rd_b_ph);   // next cycle
	assign dq_rd        = dq_in;

	// ------------------------------
	// slot decisions
	// ------------------------------
	always_comb begin
		cmd_n   = nop;
		a_n     = sd_a;
		ba_n    = sd_ba;
		dqm_n   = 2'b11;
		dout_n  = dq_out;
		oe_n    = 1'b0;
		rfsh_go = 1'b0;
		if (!ready) begin
			cmd_n = init_cmd;  // startup owns the bus
			if (init_cmd != nop) begin
				a_n  = init_a;
				ba_n = '0;
			end
		end else if (phase == ras_a) begin
			if (pending_a) begin
				cmd_n = active;
				a_n   = row_a;
				ba_n  = bank_a;
			end
		end else if (phase == cas_a_ph) begin
			if (busy_a) begin
				cmd_n = we_l_a ? write : read;
				a_n   = {2'b00, 1'b1, 1'b0, col_a};  // a10 auto precharge
				ba_n  = bank_a;
				dqm_n = ~ds_l_a;
				if (we_l_a) begin
					oe_n   = 1'b1;
					dout_n = din_l_a;
				end
			end
		end else if (phase == ras_b) begin
			if (pending_b) begin
				cmd_n = active;
				a_n   = row_b;
				ba_n  = bank_b;
			end else if (need_rfsh && !busy_a) begin
				// all banks idle only with port a's slot empty
				cmd_n   = auto_refresh;
				rfsh_go = 1'b1;
			end
		end else if (phase == cas_b_ph) begin
			if (busy_b) begin
				cmd_n = we_l_b ? write : read;
				a_n   = {2'b00, 1'b1, 1'b0, col_b};
				ba_n  = bank_b;
				dqm_n = ~ds_l_b;
				if (we_l_b) begin
					oe_n   = 1'b1;
					dout_n = din_l_b;
				end
			end
		end
	end

	// ------------------------------
	// phase, refresh timer, control pins
	// ------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			phase    <= ras_a;
			cmd      <= nop;
			dqm      <= 2'b11;
			dq_oe    <= 1'b0;
			rfsh_cnt <= '0;
		end else begin
			phase <= (phase == cas_b) ? ras_a : phase_t'(phase + 3'd1);
			cmd   <= cmd_n;
			dqm   <= dqm_n;
			dq_oe <= oe_n;
			if (rfsh_go)
				rfsh_cnt <= '0;
			else if (!need_rfsh)
				rfsh_cnt <= rfsh_cnt + 1'b1;  // hold at the limit
		end
	end

	// address and data pins
	always_ff @(posedge clk) begin
		sd_a   <= a_n;
		sd_ba  <= ba_n;
		dq_out <= dout_n;
	end

endmodule

`default_nettype wire

/* hw/sdram_ctrl.sv */
// two-port sdram controller

`timescale 1ns/10ps
`default_nettype none

module sdram_ctrl (
	input  logic              clk,
	input  logic              init_n,
	// port a, banks 0 and 1
	input  logic              port_a_req,
	input  logic              port_a_we,
	input  sdram_pkg::waddr_t port_a_a,
	input  sdram_pkg::mask_t  port_a_ds,
	input  sdram_pkg::word_t  port_a_d,
	output logic              port_a_ack,
	output sdram_pkg::word_t  port_a_q,
	// port b, banks 2 and 3
	input  logic              port_b_req,
	input  logic              port_b_we,
	input  sdram_pkg::waddr_t port_b_a,
	input  sdram_pkg::mask_t  port_b_ds,
	input  sdram_pkg::word_t  port_b_d,
	output logic              port_b_ack,
	output sdram_pkg::word_t  port_b_q,
	// chip, dq split for a pad wrapper
	input  sdram_pkg::word_t  sd_dq_in,
	output sdram_pkg::cmd_t   sd_cmd,
	output sdram_pkg::row_t   sd_a,
	output sdram_pkg::bank_t  sd_ba,
	output sdram_pkg::mask_t  sd_dqm,
	output sdram_pkg::word_t  sd_dq_out,
	output logic              sd_dq_oe
);

	import sdram_pkg::*;

	phase_t phase;
	cmd_t   init_cmd;
	row_t   init_a;
	logic   ready;
	word_t  dq_rd;

	// port a to scheduler
	logic  pend_a, we_l_a, oe_l_a, acc_a, wdone_a, rdone_a;
	bank_t bank_a;
	row_t  row_a;
	col_t  col_a;
	mask_t ds_l_a;
	word_t din_l_a;

	// port b to scheduler
	logic  pend_b, we_l_b, oe_l_b, acc_b, wdone_b, rdone_b;
	bank_t bank_b;
	row_t  row_b;
	col_t  col_b;
	mask_t ds_l_b;
	word_t din_l_b;

	sdram_init u_init (
		.clk, .init_n, .phase,
		.init_cmd, .init_a, .ready
	);

	sdram_sched u_sched (
		.clk, .init_n, .ready, .init_cmd, .init_a, .phase,
		.pending_a(pend_a), .bank_a, .row_a, .col_a,
		.we_l_a, .oe_l_a, .ds_l_a, .din_l_a,
		.accept_a(acc_a), .write_done_a(wdone_a), .read_done_a(rdone_a),
		.pending_b(pend_b), .bank_b, .row_b, .col_b,
		.we_l_b, .oe_l_b, .ds_l_b, .din_l_b,
		.accept_b(acc_b), .write_done_b(wdone_b), .read_done_b(rdone_b),
		.dq_in(sd_dq_in), .dq_rd,
		.cmd(sd_cmd), .sd_a, .sd_ba, .dqm(sd_dqm),
		.dq_out(sd_dq_out), .dq_oe(sd_dq_oe)
	);

	sdram_port #(.bank_hi(1'b0)) port_a (
		.clk, .init_n,
		.req(port_a_req), .we(port_a_we), .a(port_a_a), .ds(port_a_ds),
		.d(port_a_d), .ack(port_a_ack), .q(port_a_q),
		.accept(acc_a), .write_done(wdone_a), .read_done(rdone_a), .dq_in(dq_rd),
		.pending(pend_a), .bank(bank_a), .row(row_a), .col(col_a),
		.we_l(we_l_a), .oe_l(oe_l_a), .ds_l(ds_l_a), .din_l(din_l_a)
	);

	sdram_port #(.bank_hi(1'b1)) port_b (
		.clk, .init_n,
		.req(port_b_req), .we(port_b_we), .a(port_b_a), .ds(port_b_ds),
		.d(port_b_d), .ack(port_b_ack), .q(port_b_q),
		.accept(acc_b), .write_done(wdone_b), .read_done(rdone_b), .dq_in(dq_rd),
		.pending(pend_b), .bank(bank_b), .row(row_b), .col(col_b),
		.we_l(we_l_b), .oe_l(oe_l_b), .ds_l(ds_l_b), .din_l(din_l_b)
	);

endmodule

`default_nettype wire

/* test/sdram_chip_model.sv */
// behavioral sdr sdram chip

`timescale 1ns/10ps
`default_nettype none

module sdram_chip_model (
	input  logic             clk,
	input  sdram_pkg::cmd_t  cmd,
	input  sdram_pkg::row_t  a,
	input  sdram_pkg::bank_t ba,
	input  sdram_pkg::mask_t dqm,      // high masks the byte
	input  sdram_pkg::word_t dq,       // write data from the controller
	input  logic             dq_oe,
	output sdram_pkg::word_t dq_rd,    // read data back to the controller
	output logic             illegal   // sticky, set on a bad command order
);

	import sdram_pkg::*;

	word_t      mem [logic [23:0]];  // keyed by bank, row, col
	logic [3:0] open_bank;           // one bit per bank
	row_t       open_row [4];
	logic       mode_set;            // load_mode seen
	word_t      rd_stage;            // cl2: one clock inside the chip
	logic       rd_valid;

	initial begin
		open_bank = '0;
		mode_set  = 1'b0;
		rd_stage  = '0;
		rd_valid  = 1'b0;
		dq_rd     = '0;
		illegal   = 1'b0;
	end

	// never-written words, a pattern over the whole address
	function automatic word_t fill_word(input logic [23:0] key);
		return key[15:0] ^ {key[23:16], key[23:16]};
	endfunction

	function automatic word_t stored(input logic [23:0] key);
		if (mem.exists(key))
			return mem[key];
		return fill_word(key);
	endfunction

	task automatic flag_illegal(input string what);
		$display("chip model: %s, bank %0d at %0t ns", what, ba, $time);
		illegal <= 1'b1;
	endtask

	// ------------------------------
	// command decode
	// ------------------------------
	always @(posedge clk) begin
		logic [23:0] key;
		word_t       w;
		key      = {ba, open_row[ba], a[8:0]};  // row from the open bank
		rd_valid <= 1'b0;
		dq_rd    <= rd_valid ? rd_stage : '0;   // data out 2 clocks after read
		if (dq_oe === 1'b1 && cmd != write)
			flag_illegal("dq driven without a write command");  // bus fight on reads
		case (cmd)
			active: begin
				if (!mode_set)
					flag_illegal("ACTIVE before load_mode");
				else if (open_bank[ba])
					flag_illegal("ACTIVE to a bank that is already open");
				open_bank[ba] = 1'b1;
				open_row[ba]  = a;
			end
			read, write: begin
				if (!mode_set)
					flag_illegal("read or write before load_mode");
				else if (!open_bank[ba])
					flag_illegal("read or write to a bank without an open row");
				else if (cmd == write) begin
					if (!dq_oe)
						flag_illegal("write without driven data");
					w = stored(key);
					if (!dqm[1])
						w[15:8] = dq[15:8];  // upper byte enabled
					if (!dqm[0])
						w[7:0] = dq[7:0];
					mem[key] = w;
				end else begin
					rd_stage <= stored(key);
					rd_valid <= 1'b1;
				end
				if (a[10])
					open_bank[ba] = 1'b0;  // auto precharge
			end
			precharge: begin
				if (a[10])
					open_bank = '0;  // all banks
				else
					open_bank[ba] = 1'b0;
			end
			auto_refresh: begin
				if (open_bank != '0)
					flag_illegal("auto refresh with a bank open");
			end
			load_mode: begin
				if (open_bank != '0)
					flag_illegal("load_mode with a bank open");
				mode_set = 1'b1;
			end
			default: ;  // nop, inhibit, burst_term
		endcase
	end

endmodule

`default_nettype wire

/* test/tb_sdram.sv */
// sdram controller testbench

`timescale 1ns/10ps
`default_nettype none

`include "sdram_settings.svh"

module tb_sdram;

	import sdram_pkg::*;

	// ------------------------------
	// run length
	// ------------------------------
	localparam int n_single  = 24;   // write/read pairs per port
	localparam int n_mask    = 16;   // masked pairs per port
	localparam int n_conc    = 100;  // per port, both at once
	localparam int n_txn     = 2 + 4 * n_single + 4 * n_mask + 2 * n_conc;
	localparam int reset_clk = 16;
	localparam int boot_clk  = reset_clk + 6 * `SDRAM_INIT_CYCLES;
	localparam int rfsh_clk  = 3 * `SDRAM_REFRESH_CYCLES;  // port b idle stretch
	localparam int ack_limit = boot_clk + 100;             // clocks per access
	localparam int wd_clk    = n_txn * 12 + boot_clk + rfsh_clk
		+ 2 * `SDRAM_REFRESH_CYCLES + 1000;

	logic   clk;
	logic   init_n;
	logic   port_a_req, port_a_we, port_a_ack;
	waddr_t port_a_a;
	mask_t  port_a_ds;
	word_t  port_a_d, port_a_q;
	logic   port_b_req, port_b_we, port_b_ack;
	waddr_t port_b_a;
	mask_t  port_b_ds;
	word_t  port_b_d, port_b_q;
	word_t  sd_dq_in, sd_dq_out;
	cmd_t   sd_cmd;
	row_t   sd_a;
	bank_t  sd_ba;
	mask_t  sd_dqm;
	logic   sd_dq_oe;
	logic   chip_illegal;

	word_t  shadow [logic [23:0]];  // reference memory, key {port, addr}
	waddr_t written_a [$];          // addresses each port has written
	waddr_t written_b [$];
	int     clk_cnt    = 0;
	int     n_init     = 0;     // startup commands seen
	int     n_rfsh     = 0;
	int     last_rfsh  = 0;
	int     last_act_a = -100;  // clock of port a's last active
	cmd_t   boot_seq [4] = '{precharge, auto_refresh, auto_refresh, load_mode};

	sdram_ctrl DUT (
		.clk, .init_n,
		.port_a_req, .port_a_we, .port_a_a, .port_a_ds, .port_a_d,
		.port_a_ack, .port_a_q,
		.port_b_req, .port_b_we, .port_b_a, .port_b_ds, .port_b_d,
		.port_b_ack, .port_b_q,
		.sd_dq_in, .sd_cmd, .sd_a, .sd_ba, .sd_dqm, .sd_dq_out, .sd_dq_oe
	);

	sdram_chip_model chip (
		.clk, .cmd(sd_cmd), .a(sd_a), .ba(sd_ba), .dqm(sd_dqm),
		.dq(sd_dq_out), .dq_oe(sd_dq_oe), .dq_rd(sd_dq_in), .illegal(chip_illegal)
	);

	always #5 clk = ~clk;  // 10 ns

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic word_t merge_bytes(input word_t old, input word_t data, input mask_t m);
		word_t w;
		w = old;
		if (m[1])
			w[15:8] = data[15:8];
		if (m[0])
			w[7:0] = data[7:0];
		return w;
	endfunction

	function automatic logic port_done(input bit p);
		return p ? (port_b_ack == port_b_req) : (port_a_ack == port_a_req);
	endfunction

	function automatic waddr_t pick_written(input bit p);
		if (p)
			return written_b[$urandom % written_b.size()];
		return written_a[$urandom % written_a.size()];
	endfunction

	// ------------------------------
	// one toggle handshake
	// ------------------------------
	task automatic run_access(input bit p, input bit wr, input waddr_t addr,
		input mask_t m, input word_t data);
		logic [23:0] key;
		word_t       expect_q;
		word_t       got;
		int          waited;
		key      = {p, addr};
		expect_q = shadow.exists(key) ? shadow[key] : '0;
		@(negedge clk);
		if (wr) begin
			if (!shadow.exists(key)) begin
				if (p)
					written_b.push_back(addr);
				else
					written_a.push_back(addr);
			end
			shadow[key] = merge_bytes(expect_q, data, m);  // on issue
		end
		if (!p) begin
			port_a_we  = wr;
			port_a_a   = addr;
			port_a_ds  = m;
			port_a_d   = data;
			port_a_req = ~port_a_req;
		end else begin
			port_b_we  = wr;
			port_b_a   = addr;
			port_b_ds  = m;
			port_b_d   = data;
			port_b_req = ~port_b_req;
		end
		waited = 0;
		while (!port_done(p) && waited < ack_limit) begin
			@(negedge clk);
			waited++;
		end
		assert (port_done(p))
		else report_failure($sformatf("port %s got no ack within %0d clocks",
			p ? "B" : "A", ack_limit));
		got = p ? port_b_q : port_a_q;
		if (!wr)
			assert (got == expect_q)
			else report_failure($sformatf("ERR port_%s_q got %h expected %h",
				p ? "b" : "a", got, expect_q));
	endtask

	task automatic random_traffic(input bit p, input int n, input int max_gap);
		int     kind;
		mask_t  m;
		repeat (n) begin
			repeat ($urandom % (max_gap + 1)) @(negedge clk);  // idle gap
			kind = $urandom % 4;
			m    = mask_t'(1 + $urandom % 3);  // 01, 10 or 11
			if (kind == 0)
				run_access(p, 1'b1, waddr_t'($urandom), 2'b11, word_t'($urandom));
			else if (kind == 1)
				run_access(p, 1'b1, pick_written(p), m, word_t'($urandom));
			else
				run_access(p, 1'b0, pick_written(p), 2'b11, '0);
		end
	endtask

	// ------------------------------
	// bus monitor
	// ------------------------------
	always @(negedge clk) begin
		clk_cnt = clk_cnt + 1;
		if (init_n) begin
			assert (!chip_illegal)
			else report_failure("chip model saw an illegal command order");
			if (n_init < 4)
				assert (!port_a_ack && !port_b_ack)
				else report_failure($sformatf("ERR ack before load_mode port_a_ack %h port_b_ack %h",
					port_a_ack, port_b_ack));
			if (sd_cmd != nop && sd_cmd != inhibit && n_init < 4) begin
				assert (sd_cmd == boot_seq[n_init])
				else report_failure($sformatf("ERR sd_cmd got %h expected %h",
					sd_cmd, boot_seq[n_init]));
				if (n_init == 0)
					assert (sd_a[10])
					else report_failure($sformatf("ERR sd_a[10] got %h expected 1", sd_a[10]));
				if (n_init == 3)
					assert (sd_a == 13'h220 && sd_ba == 2'b00)
					else report_failure($sformatf("ERR sd_a got %h expected 220 sd_ba got %h expected 0",
						sd_a, sd_ba));
				n_init++;
			end else if (sd_cmd == active && !sd_ba[1]) begin
				assert (port_a_req != port_a_ack)
				else report_failure("active on port A banks with no port A request open");
				assert (sd_ba[0] == port_a_a[23] && sd_a == port_a_a[22:10])
				else report_failure($sformatf("ERR sd_ba got %h expected %h sd_a got %h expected %h",
					sd_ba, {1'b0, port_a_a[23]}, sd_a, port_a_a[22:10]));
				last_act_a = clk_cnt;
			end else if (sd_cmd == active) begin
				assert (port_b_req != port_b_ack)
				else report_failure("active on port B banks with no port B request open");
				assert (sd_ba[0] == port_b_a[23] && sd_a == port_b_a[22:10])
				else report_failure($sformatf("ERR sd_ba got %h expected %h sd_a got %h expected %h",
					sd_ba, {1'b1, port_b_a[23]}, sd_a, port_b_a[22:10]));
			end else if (sd_cmd == auto_refresh) begin
				// port a's active sits 3 clocks before b's slot
				assert (clk_cnt - last_act_a != 3)
				else report_failure("auto refresh issued in a cycle where port A holds an access");
				assert (n_rfsh == 0 || clk_cnt - last_rfsh >= `SDRAM_REFRESH_CYCLES)
				else report_failure($sformatf("ERR refresh spacing got %h clocks expected at least %h",
					clk_cnt - last_rfsh, `SDRAM_REFRESH_CYCLES));
				last_rfsh = clk_cnt;
				n_rfsh++;
			end
		end
	end

	initial begin
		repeat (wd_clk) @(posedge clk);
		report_failure($sformatf("watchdog: run did not end within %0d clocks", wd_clk));
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		waddr_t addr;
		word_t  data;
		mask_t  m;
		int     start;
		int     rfsh_before;
		clk        = 1'b0;
		init_n     = 1'b0;
		port_a_req = 1'b0;
		port_a_we  = 1'b0;
		port_a_a   = '0;
		port_a_ds  = 2'b11;
		port_a_d   = '0;
		port_b_req = 1'b0;
		port_b_we  = 1'b0;
		port_b_a   = '0;
		port_b_ds  = 2'b11;
		port_b_d   = '0;
		void'($urandom(32'he68b));
		repeat (reset_clk) @(posedge clk);
		@(negedge clk);
		init_n = 1'b1;

		// requests toggled long before the chip is ready
		fork
			run_access(1'b0, 1'b1, waddr_t'($urandom), 2'b11, word_t'($urandom));
			run_access(1'b1, 1'b1, waddr_t'($urandom), 2'b11, word_t'($urandom));
		join
		assert (n_init == 4)
		else report_failure("startup command sequence did not complete");

		// read after write, port a then port b
		for (int p = 0; p < 2; p++) begin
			repeat (n_single) begin
				addr = waddr_t'($urandom);
				data = word_t'($urandom);
				run_access(p[0], 1'b1, addr, 2'b11, data);
				run_access(p[0], 1'b0, addr, 2'b11, '0);
			end
		end

		// single byte writes over known words
		for (int p = 0; p < 2; p++) begin
			repeat (n_mask) begin
				addr = pick_written(p[0]);
				m    = ($urandom % 2) ? 2'b10 : 2'b01;
				run_access(p[0], 1'b1, addr, m, word_t'($urandom));
				run_access(p[0], 1'b0, addr, 2'b11, '0);
			end
		end

		fork
			random_traffic(1'b0, n_conc, 7);
			random_traffic(1'b1, n_conc, 7);
		join

		// port b idle, refresh must get through
		start       = clk_cnt;
		rfsh_before = n_rfsh;
		while (clk_cnt - start < rfsh_clk)
			random_traffic(1'b0, 1, 15);
		assert (n_rfsh - rfsh_before >= 2)
		else report_failure("too few auto refreshes while port B was idle");

		repeat (10) @(negedge clk);
		if (!chip_illegal) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			report_failure("chip model flagged an illegal command at the end");
		end
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hw/sdram_pkg.sv
hw/sdram_init.sv
hw/sdram_port.sv
hw/sdram_sched.sv
hw/sdram_ctrl.sv
test/sdram_chip_model.sv
test/tb_sdram.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sdram controller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sdram -f project.f

./obj_dir/Vtb_sdram 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "testbench reported a failure"
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "testbench ended without a result"
	exit 1
fi
echo "testbench passed"
